// ==== design/llc_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module llc_core import llc_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       req_valid_i,
    output logic            req_ready_o,
    input  wire req_op_t    req_op_i,
    input  wire line_addr_t req_addr_i,
    input  wire line_t      req_line_i,
    input  wire logic       dma_req_valid_i,
    output logic            dma_req_ready_o,
    input  wire req_op_t    dma_req_op_i,
    input  wire line_addr_t dma_req_addr_i,
    input  wire line_t      dma_req_line_i,
    input  wire logic       mem_rsp_valid_i,
    output logic            mem_rsp_ready_o,
    input  wire line_t      mem_rsp_line_i,
    output logic            rsp_valid_o,
    input  wire logic       rsp_ready_i,
    output line_addr_t      rsp_addr_o,
    output line_t           rsp_line_o,
    output logic            dma_rsp_valid_o,
    input  wire logic       dma_rsp_ready_i,
    output line_addr_t      dma_rsp_addr_o,
    output line_t           dma_rsp_line_o,
    output logic            mem_req_valid_o,
    input  wire logic       mem_req_ready_i,
    output req_op_t         mem_req_op_o,
    output line_addr_t      mem_req_addr_o,
    output line_t           mem_req_line_o
);

    llc_core_state_t state;
    llc_core_state_t next_state;

    logic       decode_en;
    logic       rd_en;
    logic       lookup_en;
    logic       process_en;
    logic       update_en;
    logic       req_taken;
    logic       process_done;
    req_op_t    cur_op;
    line_addr_t cur_addr;
    line_t      cur_line;
    logic       cur_is_dma;
    llc_set_t   cur_set;
    llc_tag_t   cur_tag;

    llc_tag_t   rd_tag [LLC_WAYS];
    llc_state_t rd_state [LLC_WAYS];
    line_t      rd_line [LLC_WAYS];
    llc_way_t   rd_evict_way;
    logic       hit;
    llc_way_t   hit_way;
    llc_way_t   victim_way;

    logic       wr_en;
    llc_way_t   wr_way;
    llc_tag_t   wr_tag;
    llc_state_t wr_state;
    line_t      wr_line;
    logic       incr_evict;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= DECODE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            DECODE:   if (req_taken) next_state = READ_MEM;
            READ_MEM: next_state = LOOKUP;
            LOOKUP:   next_state = PROCESS;
            PROCESS:  if (process_done) next_state = UPDATE;
            default:  next_state = DECODE;
        endcase
    end

    assign decode_en  = (state == DECODE);
    assign rd_en      = (state == READ_MEM);
    assign lookup_en  = (state == LOOKUP);
    assign process_en = (state == PROCESS);
    assign update_en  = (state == UPDATE);

    // set and tag of the captured request
    assign cur_set = cur_addr[LLC_SET_BITS-1:0];
    assign cur_tag = cur_addr[ADDR_BITS-1 -: LLC_TAG_BITS];

    llc_input_decoder i_input_decoder (
        .clk             (clk),
        .rst             (rst),
        .decode_en_i     (decode_en),
        .req_valid_i     (req_valid_i),
        .req_op_i        (req_op_i),
        .req_addr_i      (req_addr_i),
        .req_line_i      (req_line_i),
        .dma_req_valid_i (dma_req_valid_i),
        .dma_req_op_i    (dma_req_op_i),
        .dma_req_addr_i  (dma_req_addr_i),
        .dma_req_line_i  (dma_req_line_i),
        .req_ready_o     (req_ready_o),
        .dma_req_ready_o (dma_req_ready_o),
        .req_taken_o     (req_taken),
        .cur_op_o        (cur_op),
        .cur_addr_o      (cur_addr),
        .cur_line_o      (cur_line),
        .cur_is_dma_o    (cur_is_dma)
    );

    llc_localmem i_localmem (
        .clk            (clk),
        .rst            (rst),
        .rd_en_i        (rd_en),
        .rd_set_i       (cur_set),
        .wr_en_i        (update_en & wr_en),
        .wr_set_i       (cur_set),
        .wr_way_i       (wr_way),
        .wr_tag_i       (wr_tag),
        .wr_state_i     (wr_state),
        .wr_line_i      (wr_line),
        .incr_evict_i   (update_en & incr_evict),
        .rd_tag_o       (rd_tag),
        .rd_state_o     (rd_state),
        .rd_line_o      (rd_line),
        .rd_evict_way_o (rd_evict_way)
    );

    llc_lookup_way i_lookup_way (
        .clk            (clk),
        .rst            (rst),
        .lookup_en_i    (lookup_en),
        .tag_i          (cur_tag),
        .rd_tag_i       (rd_tag),
        .rd_state_i     (rd_state),
        .rd_evict_way_i (rd_evict_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way)
    );

    llc_process_request i_process_request (
        .clk             (clk),
        .rst             (rst),
        .process_en_i    (process_en),
        .cur_op_i        (cur_op),
        .cur_addr_i      (cur_addr),
        .cur_line_i      (cur_line),
        .cur_is_dma_i    (cur_is_dma),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .victim_way_i    (victim_way),
        .rd_tag_i        (rd_tag),
        .rd_state_i      (rd_state),
        .rd_line_i       (rd_line),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_line_i  (mem_rsp_line_i),
        .rsp_ready_i     (rsp_ready_i),
        .dma_rsp_ready_i (dma_rsp_ready_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_op_o    (mem_req_op_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_line_o  (mem_req_line_o),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_addr_o      (rsp_addr_o),
        .rsp_line_o      (rsp_line_o),
        .dma_rsp_valid_o (dma_rsp_valid_o),
        .dma_rsp_addr_o  (dma_rsp_addr_o),
        .dma_rsp_line_o  (dma_rsp_line_o),
        .process_done_o  (process_done),
        .wr_en_o         (wr_en),
        .wr_way_o        (wr_way),
        .wr_tag_o        (wr_tag),
        .wr_state_o      (wr_state),
        .wr_line_o       (wr_line),
        .incr_evict_o    (incr_evict)
    );

endmodule

`default_nettype wire

// ==== design/llc_input_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module llc_input_decoder import llc_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       decode_en_i,
    input  wire logic       req_valid_i,
    input  wire req_op_t    req_op_i,
    input  wire line_addr_t req_addr_i,
    input  wire line_t      req_line_i,
    input  wire logic       dma_req_valid_i,
    input  wire req_op_t    dma_req_op_i,
    input  wire line_addr_t dma_req_addr_i,
    input  wire line_t      dma_req_line_i,
    output logic            req_ready_o,
    output logic            dma_req_ready_o,
    output logic            req_taken_o,
    output req_op_t         cur_op_o,
    output line_addr_t      cur_addr_o,
    output line_t           cur_line_o,
    output logic            cur_is_dma_o
);

    // coherent requester wins over dma
    assign req_ready_o     = decode_en_i & req_valid_i;
    assign dma_req_ready_o = decode_en_i & ~req_valid_i & dma_req_valid_i;
    assign req_taken_o     = req_ready_o | dma_req_ready_o;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cur_op_o     <= OP_READ;
            cur_is_dma_o <= 1'b0;
        end else if (req_taken_o) begin
            cur_op_o     <= req_ready_o ? req_op_i : dma_req_op_i;
            cur_is_dma_o <= dma_req_ready_o;
        end
    end

    // payload of the taken request
    always_ff @(posedge clk) begin
        if (req_taken_o) begin
            cur_addr_o <= req_ready_o ? req_addr_i : dma_req_addr_i;
            cur_line_o <= req_ready_o ? req_line_i : dma_req_line_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/llc_localmem.sv ====
`timescale 1ns/1ps
`default_nettype none

module llc_localmem import llc_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       rd_en_i,
    input  wire llc_set_t   rd_set_i,
    input  wire logic       wr_en_i,
    input  wire llc_set_t   wr_set_i,
    input  wire llc_way_t   wr_way_i,
    input  wire llc_tag_t   wr_tag_i,
    input  wire llc_state_t wr_state_i,
    input  wire line_t      wr_line_i,
    input  wire logic       incr_evict_i,
    output llc_tag_t        rd_tag_o [LLC_WAYS],
    output llc_state_t      rd_state_o [LLC_WAYS],
    output line_t           rd_line_o [LLC_WAYS],
    output llc_way_t        rd_evict_way_o
);

    llc_tag_t   tag_mem [LLC_WAYS][LLC_SETS];
    line_t      line_mem [LLC_WAYS][LLC_SETS];
    llc_state_t state_mem [LLC_WAYS][LLC_SETS];
    llc_way_t   evict_ptr [LLC_SETS];

    // states and evict pointers come up cleared
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < LLC_SETS; s++) begin
                evict_ptr[s] <= '0;
                for (int w = 0; w < LLC_WAYS; w++) begin
                    state_mem[w][s] <= INVALID;
                end
            end
        end else begin
            if (wr_en_i) begin
                state_mem[wr_way_i][wr_set_i] <= wr_state_i;
            end
            if (incr_evict_i) begin
                evict_ptr[wr_set_i] <= llc_way_t'(evict_ptr[wr_set_i] + 1'b1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[wr_way_i][wr_set_i]  <= wr_tag_i;
            line_mem[wr_way_i][wr_set_i] <= wr_line_i;
        end
    end

    // registered read of the whole set
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                rd_tag_o[w]   <= tag_mem[w][rd_set_i];
                rd_state_o[w] <= state_mem[w][rd_set_i];
                rd_line_o[w]  <= line_mem[w][rd_set_i];
            end
            rd_evict_way_o <= evict_ptr[rd_set_i];
        end
    end

endmodule

`default_nettype wire

// ==== design/llc_lookup_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module llc_lookup_way import llc_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       lookup_en_i,
    input  wire llc_tag_t   tag_i,
    input  wire llc_tag_t   rd_tag_i [LLC_WAYS],
    input  wire llc_state_t rd_state_i [LLC_WAYS],
    input  wire llc_way_t   rd_evict_way_i,
    output logic            hit_o,
    output llc_way_t        hit_way_o,
    output llc_way_t        victim_way_o
);

    logic     hit;
    llc_way_t hit_way;
    llc_way_t victim_way;

    always_comb begin
        hit         = 1'b0;
        hit_way     = '0;
        victim_way  = rd_evict_way_i;
        // scan high to low so the lowest way wins
        for (int w = LLC_WAYS - 1; w >= 0; w--) begin
            if (rd_state_i[w] != INVALID && rd_tag_i[w] == tag_i) begin
                hit     = 1'b1;
                hit_way = llc_way_t'(w);
            end
            if (rd_state_i[w] == INVALID) begin
                victim_way  = llc_way_t'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hit_o        <= 1'b0;
            hit_way_o    <= '0;
            victim_way_o <= '0;
        end else if (lookup_en_i) begin
            hit_o        <= hit;
            hit_way_o    <= hit_way;
            victim_way_o <= victim_way;
        end
    end

endmodule

`default_nettype wire

// ==== design/llc_pkg.sv ====
`default_nettype none

package llc_pkg;

    // cache geometry
    localparam int LLC_SETS     = 16;
    localparam int LLC_WAYS     = 4;
    localparam int LLC_SET_BITS = 4;
    localparam int LLC_WAY_BITS = 2;
    localparam int LLC_TAG_BITS = 8;
    localparam int LINE_BITS    = 32;
    localparam int ADDR_BITS    = 12;

    // line address is {tag, set}
    typedef logic [ADDR_BITS-1:0]    line_addr_t;
    typedef logic [LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [LLC_WAY_BITS-1:0] llc_way_t;
    typedef logic [LINE_BITS-1:0]    line_t;

    typedef logic [0:0] req_op_t;

    localparam req_op_t OP_READ  = 1'b0;
    localparam req_op_t OP_WRITE = 1'b1;

    // per-line state
    typedef enum logic [1:0] {
        INVALID,
        VALID,
        DIRTY
    } llc_state_t;

    // request stages
    typedef enum logic [2:0] {
        DECODE,
        READ_MEM,
        LOOKUP,
        PROCESS,
        UPDATE
    } llc_core_state_t;

endpackage

`default_nettype wire

// ==== design/llc_process_request.sv ====
`timescale 1ns/1ps
`default_nettype none

module llc_process_request import llc_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       process_en_i,
    input  wire req_op_t    cur_op_i,
    input  wire line_addr_t cur_addr_i,
    input  wire line_t      cur_line_i,
    input  wire logic       cur_is_dma_i,
    input  wire logic       hit_i,
    input  wire llc_way_t   hit_way_i,
    input  wire llc_way_t   victim_way_i,
    input  wire llc_tag_t   rd_tag_i [LLC_WAYS],
    input  wire llc_state_t rd_state_i [LLC_WAYS],
    input  wire line_t      rd_line_i [LLC_WAYS],
    input  wire logic       mem_req_ready_i,
    input  wire logic       mem_rsp_valid_i,
    input  wire line_t      mem_rsp_line_i,
    input  wire logic       rsp_ready_i,
    input  wire logic       dma_rsp_ready_i,
    output logic            mem_req_valid_o,
    output req_op_t         mem_req_op_o,
    output line_addr_t      mem_req_addr_o,
    output line_t           mem_req_line_o,
    output logic            mem_rsp_ready_o,
    output logic            rsp_valid_o,
    output line_addr_t      rsp_addr_o,
    output line_t           rsp_line_o,
    output logic            dma_rsp_valid_o,
    output line_addr_t      dma_rsp_addr_o,
    output line_t           dma_rsp_line_o,
    output logic            process_done_o,
    output logic            wr_en_o,
    output llc_way_t        wr_way_o,
    output llc_tag_t        wr_tag_o,
    output llc_state_t      wr_state_o,
    output line_t           wr_line_o,
    output logic            incr_evict_o
);

    typedef enum logic [2:0] {
        P_IDLE,
        P_WB,
        P_FETCH_REQ,
        P_FETCH_RSP,
        P_RESPOND,
        P_DONE
    } proc_state_t;

    proc_state_t p_state;
    line_t       new_line;
    logic        is_write;
    logic        victim_dirty;
    logic        rsp_ready;
    llc_set_t    cur_set;
    llc_tag_t    cur_tag;

    assign is_write     = (cur_op_i == OP_WRITE);
    assign victim_dirty = (rd_state_i[victim_way_i] == DIRTY);
    assign rsp_ready    = cur_is_dma_i ? dma_rsp_ready_i : rsp_ready_i;
    assign cur_set      = cur_addr_i[LLC_SET_BITS-1:0];
    assign cur_tag      = cur_addr_i[ADDR_BITS-1 -: LLC_TAG_BITS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            p_state <= P_IDLE;
        end else begin
            case (p_state)
                P_IDLE: begin
                    if (process_en_i) begin
                        if (hit_i) begin
                            p_state <= P_RESPOND;
                        end else if (victim_dirty) begin
                            p_state <= P_WB;
                        end else begin
                            p_state <= is_write ? P_RESPOND : P_FETCH_REQ;
                        end
                    end
                end
                P_WB: begin
                    if (mem_req_ready_i) begin
                        p_state <= is_write ? P_RESPOND : P_FETCH_REQ;
                    end
                end
                P_FETCH_REQ: begin
                    if (mem_req_ready_i) begin
                        p_state <= P_FETCH_RSP;
                    end
                end
                P_FETCH_RSP: begin
                    if (mem_rsp_valid_i) begin
                        p_state <= P_RESPOND;
                    end
                end
                P_RESPOND: begin
                    if (rsp_ready) begin
                        p_state <= P_DONE;
                    end
                end
                default: begin
                    p_state <= P_IDLE;
                end
            endcase
        end
    end

    // line after the operation
    always_ff @(posedge clk) begin
        if (p_state == P_IDLE && process_en_i) begin
            new_line <= is_write ? cur_line_i : rd_line_i[hit_way_i];
        end else if (p_state == P_FETCH_RSP && mem_rsp_valid_i) begin
            new_line <= mem_rsp_line_i;
        end
    end

    assign mem_req_valid_o = (p_state == P_WB) || (p_state == P_FETCH_REQ);
    assign mem_req_op_o    = (p_state == P_WB) ? OP_WRITE : OP_READ;
    assign mem_req_addr_o  = (p_state == P_WB) ? {rd_tag_i[victim_way_i], cur_set} : cur_addr_i;
    assign mem_req_line_o  = rd_line_i[victim_way_i];
    assign mem_rsp_ready_o = (p_state == P_FETCH_RSP);

    assign rsp_valid_o     = (p_state == P_RESPOND) && !cur_is_dma_i;
    assign dma_rsp_valid_o = (p_state == P_RESPOND) && cur_is_dma_i;
    assign rsp_addr_o      = cur_addr_i;
    assign dma_rsp_addr_o  = cur_addr_i;
    assign rsp_line_o      = new_line;
    assign dma_rsp_line_o  = new_line;
    assign process_done_o  = (p_state == P_RESPOND) && rsp_ready;

    // read hit leaves the arrays alone
    assign wr_en_o    = is_write || !hit_i;
    assign wr_way_o   = hit_i ? hit_way_i : victim_way_i;
    assign wr_tag_o   = cur_tag;
    assign wr_line_o  = new_line;
    assign wr_state_o = is_write ? DIRTY : (hit_i ? rd_state_i[hit_way_i] : VALID);

    // a valid victim can only be the evict pointer
    assign incr_evict_o = !hit_i && (rd_state_i[victim_way_i] != INVALID);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module llc_tb -f vlog.f -o llc_sim
./obj_dir/llc_sim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
echo "run finished without failures"

// ==== verif/llc_stimulus.txt ====
# ch op addr line expected, hex; ch 0 coherent, 1 dma, 2 dma sent with line above
0 0 12e 00000000 5a5a512e
0 0 12e 00000000 5a5a512e
1 0 2a7 00000000 5a5a52a7
1 0 2a7 00000000 5a5a52a7
0 1 0a1 c0de00a1 c0de00a1
0 0 0a1 00000000 c0de00a1
1 1 0b2 d0a000b2 d0a000b2
1 0 0b2 00000000 d0a000b2
1 0 0a1 00000000 c0de00a1
0 0 0b2 00000000 d0a000b2
0 1 013 aaaa0013 aaaa0013
0 0 023 00000000 5a5a5023
1 1 033 bbbb0033 bbbb0033
0 0 043 00000000 5a5a5043
0 1 053 cccc0053 cccc0053
0 0 063 00000000 5a5a5063
0 0 073 00000000 5a5a5073
0 0 013 00000000 aaaa0013
1 0 033 00000000 bbbb0033
0 0 053 00000000 cccc0053
0 0 12e 00000000 5a5a512e
2 0 2a7 00000000 5a5a52a7
0 1 3c8 123403c8 123403c8
2 1 4d9 567804d9 567804d9
0 0 4d9 00000000 567804d9
2 0 3c8 00000000 123403c8

// ==== verif/llc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module llc_tb import llc_pkg::*; ();

    localparam int MAX_REQS = 64;

    logic       clk;
    logic       rst;
    logic       req_valid;
    logic       req_ready;
    req_op_t    req_op;
    line_addr_t req_addr;
    line_t      req_line;
    logic       dma_req_valid;
    logic       dma_req_ready;
    req_op_t    dma_req_op;
    line_addr_t dma_req_addr;
    line_t      dma_req_line;
    logic       mem_rsp_valid;
    logic       mem_rsp_ready;
    line_t      mem_rsp_line;
    logic       rsp_valid;
    logic       rsp_ready;
    line_addr_t rsp_addr;
    line_t      rsp_line;
    logic       dma_rsp_valid;
    logic       dma_rsp_ready;
    line_addr_t dma_rsp_addr;
    line_t      dma_rsp_line;
    logic       mem_req_valid;
    logic       mem_req_ready;
    req_op_t    mem_req_op;
    line_addr_t mem_req_addr;
    line_t      mem_req_line;

    // stimulus table, one entry per request
    logic [1:0] st_ch [MAX_REQS];
    req_op_t    st_op [MAX_REQS];
    line_addr_t st_addr [MAX_REQS];
    line_t      st_line [MAX_REQS];
    line_t      st_exp [MAX_REQS];
    int         n_reqs;
    int         rsp_count;
    int         cycles;
    int         cycle_limit;

    line_t       mem_store [4096];
    line_t       expected_mem [4096];
    logic        fetch_pending;
    line_addr_t  fetch_addr;
    logic [31:0] lfsr_state;

    llc_core i_llc_core (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid),
        .req_ready_o     (req_ready),
        .req_op_i        (req_op),
        .req_addr_i      (req_addr),
        .req_line_i      (req_line),
        .dma_req_valid_i (dma_req_valid),
        .dma_req_ready_o (dma_req_ready),
        .dma_req_op_i    (dma_req_op),
        .dma_req_addr_i  (dma_req_addr),
        .dma_req_line_i  (dma_req_line),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_ready_o (mem_rsp_ready),
        .mem_rsp_line_i  (mem_rsp_line),
        .rsp_valid_o     (rsp_valid),
        .rsp_ready_i     (rsp_ready),
        .rsp_addr_o      (rsp_addr),
        .rsp_line_o      (rsp_line),
        .dma_rsp_valid_o (dma_rsp_valid),
        .dma_rsp_ready_i (dma_rsp_ready),
        .dma_rsp_addr_o  (dma_rsp_addr),
        .dma_rsp_line_o  (dma_rsp_line),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_req_op_o    (mem_req_op),
        .mem_req_addr_o  (mem_req_addr),
        .mem_req_line_o  (mem_req_line)
    );

    always #2 clk = ~clk;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("MISMATCH at time %0t: %s is %h, expected %h",
                                        $time, what, actual, expected));
        end
    endtask

    task automatic load_stimulus();
        int                 fd;
        logic [8*128-1:0]   header;
        logic [1:0]         f_ch;
        req_op_t            f_op;
        line_addr_t         f_addr;
        line_t              f_line;
        line_t              f_exp;
        fd = $fopen("verif/llc_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open verif/llc_stimulus.txt");
        end else begin
            // first line names the columns
            void'($fgets(header, fd));
            while (n_reqs < MAX_REQS &&
                   $fscanf(fd, "%h %h %h %h %h", f_ch, f_op, f_addr, f_line, f_exp) == 5) begin
                st_ch[n_reqs]   = f_ch;
                st_op[n_reqs]   = f_op;
                st_addr[n_reqs] = f_addr;
                st_line[n_reqs] = f_line;
                st_exp[n_reqs]  = f_exp;
                n_reqs++;
            end
            $fclose(fd);
        end
    endtask

    // channel 0 is coherent, anything else goes to dma
    task automatic drive_request(input int k);
        if (st_ch[k] == 2'd0) begin
            req_valid <= 1'b1;
            req_op    <= st_op[k];
            req_addr  <= st_addr[k];
            req_line  <= st_line[k];
        end else begin
            dma_req_valid <= 1'b1;
            dma_req_op    <= st_op[k];
            dma_req_addr  <= st_addr[k];
            dma_req_line  <= st_line[k];
        end
        if (st_op[k] == OP_WRITE) begin
            expected_mem[st_addr[k]] = st_line[k];
        end
    endtask

    task automatic send_group(input int idx, input logic pair);
        logic pend_c;
        logic pend_d;
        pend_c = (st_ch[idx] == 2'd0);
        pend_d = (st_ch[idx] != 2'd0) || pair;
        drive_request(idx);
        if (pair) begin
            drive_request(idx + 1);
        end
        while (pend_c || pend_d) begin
            @(posedge clk);
            if (pend_c && req_ready) begin
                req_valid <= 1'b0;
                pend_c = 1'b0;
            end
            if (pend_d && dma_req_ready) begin
                dma_req_valid <= 1'b0;
                pend_d = 1'b0;
            end
        end
    endtask

    task automatic take_response(input logic is_dma, input line_addr_t addr, input line_t line);
        if (rsp_count >= n_reqs) begin
            stop_with_failure("a response arrived with no request outstanding");
        end else begin
            check_value(32'(is_dma), 32'(st_ch[rsp_count] != 2'd0), "response channel");
            check_value(32'(addr), 32'(st_addr[rsp_count]), "response address");
            check_value(line, st_exp[rsp_count], "response line");
            rsp_count <= rsp_count + 1;
        end
    endtask

    // back-pressure and the memory behind the cache
    always @(posedge clk) begin
        logic b;
        if (rst) begin
            draw_bit(b);
            rsp_ready <= b;
            draw_bit(b);
            dma_rsp_ready <= b;
            draw_bit(b);
            mem_req_ready <= b;
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req_op == OP_WRITE) begin
                    check_value(mem_req_line, expected_mem[mem_req_addr], "write-back line");
                    mem_store[mem_req_addr] = mem_req_line;
                end else begin
                    fetch_addr    = mem_req_addr;
                    fetch_pending = 1'b1;
                end
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                mem_rsp_valid <= 1'b0;
            end else if (fetch_pending && !mem_rsp_valid) begin
                // random fetch latency
                draw_bit(b);
                if (b) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_line  <= mem_store[fetch_addr];
                    fetch_pending = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            if (rsp_valid && dma_rsp_valid) begin
                stop_with_failure("both response channels were valid in the same cycle");
            end else if (rsp_valid && rsp_ready) begin
                take_response(1'b0, rsp_addr, rsp_line);
            end else if (dma_rsp_valid && dma_rsp_ready) begin
                take_response(1'b1, dma_rsp_addr, dma_rsp_line);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            stop_with_failure($sformatf("timeout, run still busy after %0d cycles", cycles));
        end
    end

    initial begin
        int   idx;
        logic pair;
        clk           = 1'b0;
        rst           = 1'b0;
        req_valid     = 1'b0;
        req_op        = OP_READ;
        req_addr      = '0;
        req_line      = '0;
        dma_req_valid = 1'b0;
        dma_req_op    = OP_READ;
        dma_req_addr  = '0;
        dma_req_line  = '0;
        mem_rsp_valid = 1'b0;
        mem_rsp_line  = '0;
        rsp_ready     = 1'b0;
        dma_rsp_ready = 1'b0;
        mem_req_ready = 1'b0;
        lfsr_state    = 32'h34f8;
        fetch_pending = 1'b0;
        fetch_addr    = '0;
        n_reqs        = 0;
        rsp_count     = 0;
        cycles        = 0;
        for (int a = 0; a < 4096; a++) begin
            mem_store[a]    = {20'h5a5a5, line_addr_t'(a)};
            expected_mem[a] = {20'h5a5a5, line_addr_t'(a)};
        end
        load_stimulus();
        cycle_limit = 400 * n_reqs + 100;

        repeat (4) @(posedge clk);
        rst <= 1'b1;

        idx = 0;
        while (idx < n_reqs) begin
            // a channel 2 line goes out together with the line above
            pair = (idx + 1 < n_reqs) && (st_ch[idx + 1] == 2'd2);
            send_group(idx, pair);
            idx = idx + (pair ? 2 : 1);
            while (rsp_count < idx) begin
                @(posedge clk);
            end
        end
        repeat (20) @(posedge clk);

        if (rsp_count != n_reqs || n_reqs == 0) begin
            stop_with_failure($sformatf("got %0d responses for %0d requests", rsp_count, n_reqs));
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/llc_pkg.sv
design/llc_input_decoder.sv
design/llc_localmem.sv
design/llc_lookup_way.sv
design/llc_process_request.sv
design/llc_core.sv
verif/llc_tb.sv
